/* src/snd_reg_pkg.sv */
package snd_reg_pkg;

   typedef logic [15:0] ioreg_addr_t;
   typedef logic [7:0]  ioreg_data_t;

   typedef logic [1:0]  duty_t;
   typedef logic [5:0]  length_t;
   typedef logic [3:0]  volume_t;
   typedef logic [2:0]  env_period_t;
   typedef logic [10:0] freq_t;

   localparam ioreg_addr_t NR21_ADDR = 16'hFF16;  // Duty and length
   localparam ioreg_addr_t NR22_ADDR = 16'hFF17;  // Envelope
   localparam ioreg_addr_t NR23_ADDR = 16'hFF18;  // Freq low byte
   localparam ioreg_addr_t NR24_ADDR = 16'hFF19;  // Trigger, length enable, freq high

   // Bits set here always read back as one
   localparam ioreg_data_t NR21_RD_MASK = 8'h3F;
   localparam ioreg_data_t NR22_RD_MASK = 8'h00;
   localparam ioreg_data_t NR23_RD_MASK = 8'hFF;
   localparam ioreg_data_t NR24_RD_MASK = 8'hBF;
   localparam ioreg_data_t UNMAPPED_RD  = 8'hFF;

endpackage

/* src/snd_timing_pkg.sv */
package snd_timing_pkg;

   typedef logic [6:0]  length_cnt_t;
   typedef logic [15:0] freq_timer_t;

   // 33 MHz / 512 Hz
   localparam int FRAME_STEP_CYCLES = 64453;
   localparam int FREQ_PRESCALE     = 32;

   localparam length_cnt_t LENGTH_FULL     = 7'd64;
   localparam freq_timer_t FREQ_TIMER_BASE = 16'd2048;

   // Bit n is the output level at duty step n
   localparam logic [3:0][7:0] DUTY_PATTERNS = {
      8'h7E,   // 75%
      8'h87,   // 50%
      8'h81,   // 25%
      8'h01    // 12.5%
   };

endpackage

/* src/snd_ch2_reg_if.sv */
`timescale 1ns/1ps

interface snd_ch2_reg_if import snd_reg_pkg::*; ();

   duty_t       duty;
   length_t     length_load_val;
   volume_t     init_volume;
   logic        env_increase;
   env_period_t env_period;
   freq_t       freq;
   logic        length_enable;
   logic        dac_enable;

   // One-cycle strobes
   logic        trigger;
   logic        length_load;
   logic        dac_write;

   modport regs (output duty, length_load_val, init_volume, env_increase, env_period,
                 freq, length_enable, dac_enable, trigger, length_load, dac_write);

   modport ctrl (input length_load_val, init_volume, env_increase, env_period,
                 length_enable, dac_enable, trigger, length_load, dac_write);

   modport gen (input duty, freq, trigger);

endinterface

/* src/snd_ioreg_file.sv */
`timescale 1ns/1ps

module snd_ioreg_file import snd_reg_pkg::*; (
   input  logic        I_CLK_33MHZ,
   input  logic        I_RESET,
   input  ioreg_addr_t ioreg_addr,
   input  ioreg_data_t ioreg_wdata,
   input  logic        ioreg_we,
   input  logic        ioreg_re,
   output ioreg_data_t ioreg_rdata,
   snd_ch2_reg_if.regs regs
);

   ioreg_data_t nr21, nr22, nr23, nr24;
   ioreg_data_t rd_value;

   always_comb begin
      case (ioreg_addr)
         NR21_ADDR: rd_value = nr21 | NR21_RD_MASK;
         NR22_ADDR: rd_value = nr22 | NR22_RD_MASK;
         NR23_ADDR: rd_value = nr23 | NR23_RD_MASK;
         NR24_ADDR: rd_value = nr24 | NR24_RD_MASK;
         default:   rd_value = UNMAPPED_RD;
      endcase
   end

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         nr21             <= '0;
         nr22             <= '0;
         nr23             <= '0;
         nr24             <= '0;
         ioreg_rdata      <= '0;
         regs.trigger     <= 1'b0;
         regs.length_load <= 1'b0;
         regs.dac_write   <= 1'b0;
      end else begin
         regs.trigger     <= 1'b0;
         regs.length_load <= 1'b0;
         regs.dac_write   <= 1'b0;
         if (ioreg_we) begin
            case (ioreg_addr)
               NR21_ADDR: begin
                  nr21             <= ioreg_wdata;
                  regs.length_load <= 1'b1;
               end
               NR22_ADDR: begin
                  nr22           <= ioreg_wdata;
                  regs.dac_write <= 1'b1;
               end
               NR23_ADDR: nr23 <= ioreg_wdata;
               NR24_ADDR: begin
                  nr24         <= ioreg_wdata;
                  regs.trigger <= ioreg_wdata[7];  // Restart bit
               end
               default: ;
            endcase
         end
         if (ioreg_re)
            ioreg_rdata <= rd_value;  // Held until next read
      end
   end

   assign regs.duty            = nr21[7:6];
   assign regs.length_load_val = nr21[5:0];
   assign regs.init_volume     = nr22[7:4];
   assign regs.env_increase    = nr22[3];
   assign regs.env_period      = nr22[2:0];
   assign regs.dac_enable      = |nr22[7:3];  // DAC powered unless vol and dir both zero
   assign regs.freq            = {nr24[2:0], nr23};
   assign regs.length_enable   = nr24[6];

   // A trigger is a single pulse; the bus never restarts the channel back to back
   a_trigger_single: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      regs.trigger |=> !regs.trigger);

endmodule

/* src/snd_frame_sequencer.sv */
`timescale 1ns/1ps

module snd_frame_sequencer import snd_timing_pkg::*; #(
   parameter int frame_step_cycles = FRAME_STEP_CYCLES
) (
   input  logic I_CLK_33MHZ,
   input  logic I_RESET,
   output logic length_tick,
   output logic env_tick
);

   logic [$clog2(frame_step_cycles)-1:0] div_cnt;
   logic [2:0]                           step;

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         div_cnt     <= '0;
         step        <= '0;
         length_tick <= 1'b0;
         env_tick    <= 1'b0;
      end else begin
         length_tick <= 1'b0;
         env_tick    <= 1'b0;
         if (div_cnt == $bits(div_cnt)'(frame_step_cycles - 1)) begin
            div_cnt     <= '0;
            step        <= step + 3'd1;
            length_tick <= ~step[0];        // Steps 0, 2, 4, 6
            env_tick    <= (step == 3'd7);
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   a_ticks_exclusive: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      !(length_tick && env_tick));

endmodule

/* src/snd_length_envelope.sv */
`timescale 1ns/1ps

module snd_length_envelope import snd_reg_pkg::*, snd_timing_pkg::*; (
   input  logic        I_CLK_33MHZ,
   input  logic        I_RESET,
   snd_ch2_reg_if.ctrl ctrl,
   input  logic        length_tick,
   input  logic        env_tick,
   output logic        channel_on,
   output volume_t     volume
);

   typedef enum logic {ST_OFF, ST_PLAYING} ch_state_t;

   ch_state_t   state;
   length_cnt_t len_cnt;
   env_period_t env_timer;
   logic        len_step;

   // Length tick that takes effect this cycle
   assign len_step = length_tick && ctrl.length_enable && (len_cnt != '0);

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         state     <= ST_OFF;
         len_cnt   <= '0;
         env_timer <= '0;
         volume    <= '0;
      end else begin
         // Length counter
         if (ctrl.length_load)
            len_cnt <= LENGTH_FULL - length_cnt_t'(ctrl.length_load_val);
         else if (ctrl.trigger) begin
            if (len_cnt == '0)
               len_cnt <= LENGTH_FULL;
         end else if (len_step)
            len_cnt <= len_cnt - 1'b1;

         // Channel enable
         if (ctrl.trigger)
            state <= ctrl.dac_enable ? ST_PLAYING : ST_OFF;
         else if (ctrl.dac_write && !ctrl.dac_enable)
            state <= ST_OFF;
         else if (len_step && len_cnt == length_cnt_t'(1))
            state <= ST_OFF;  // Length expired

         // Envelope
         if (ctrl.trigger) begin
            volume    <= ctrl.init_volume;
            env_timer <= ctrl.env_period;
         end else if (env_tick && ctrl.env_period != '0) begin
            if (env_timer <= env_period_t'(1)) begin
               env_timer <= ctrl.env_period;
               if (ctrl.env_increase && volume != '1)
                  volume <= volume + 1'b1;
               else if (!ctrl.env_increase && volume != '0)
                  volume <= volume - 1'b1;
            end else begin
               env_timer <= env_timer - 1'b1;
            end
         end
      end
   end

   assign channel_on = (state == ST_PLAYING);

   // Period zero freezes the envelope between triggers
   a_env_frozen: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      (ctrl.env_period == '0 && !ctrl.trigger) |=> $stable(volume));

endmodule

/* src/snd_square_gen.sv */
`timescale 1ns/1ps

module snd_square_gen import snd_reg_pkg::*, snd_timing_pkg::*; (
   input  logic       I_CLK_33MHZ,
   input  logic       I_RESET,
   snd_ch2_reg_if.gen gen,
   input  logic       channel_on,
   input  volume_t    volume,
   output volume_t    sample
);

   logic [$clog2(FREQ_PRESCALE)-1:0] prescale_cnt;
   freq_timer_t                      freq_timer;
   freq_timer_t                      timer_reload;
   logic [2:0]                       duty_step;
   logic                             pattern_bit;

   assign timer_reload = FREQ_TIMER_BASE - freq_timer_t'(gen.freq);

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         prescale_cnt <= '0;
         freq_timer   <= '0;
         duty_step    <= '0;
      end else if (gen.trigger) begin
         prescale_cnt <= '0;
         freq_timer   <= timer_reload;
         duty_step    <= '0;
      end else if (prescale_cnt == $bits(prescale_cnt)'(FREQ_PRESCALE - 1)) begin
         prescale_cnt <= '0;
         if (freq_timer <= freq_timer_t'(1)) begin
            freq_timer <= timer_reload;
            duty_step  <= duty_step + 3'd1;
         end else begin
            freq_timer <= freq_timer - 1'b1;
         end
      end else begin
         prescale_cnt <= prescale_cnt + 1'b1;
      end
   end

   assign pattern_bit = DUTY_PATTERNS[gen.duty][duty_step];

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET)
         sample <= '0;
      else
         sample <= (pattern_bit && channel_on) ? volume : '0;  // Silent when off
   end

endmodule

/* src/snd_channel2.sv */
`timescale 1ns/1ps

module snd_channel2 import snd_reg_pkg::*, snd_timing_pkg::*; #(
   parameter int frame_step_cycles = FRAME_STEP_CYCLES
) (
   input  logic        I_CLK_33MHZ,
   input  logic        I_RESET,
   input  ioreg_addr_t ioreg_addr,
   input  ioreg_data_t ioreg_wdata,
   input  logic        ioreg_we,
   input  logic        ioreg_re,
   output ioreg_data_t ioreg_rdata,
   output logic        ch2_on,
   output volume_t     ch2_sample
);

   logic    length_tick;
   logic    env_tick;
   volume_t cur_volume;

   snd_ch2_reg_if ch2_regs ();

   snd_ioreg_file u_ioreg_file (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .ioreg_addr  (ioreg_addr),
      .ioreg_wdata (ioreg_wdata),
      .ioreg_we    (ioreg_we),
      .ioreg_re    (ioreg_re),
      .ioreg_rdata (ioreg_rdata),
      .regs        (ch2_regs.regs)
   );

   snd_frame_sequencer #(
      .frame_step_cycles (frame_step_cycles)
   ) u_frame_seq (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .length_tick (length_tick),
      .env_tick    (env_tick)
   );

   snd_length_envelope u_len_env (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .ctrl        (ch2_regs.ctrl),
      .length_tick (length_tick),
      .env_tick    (env_tick),
      .channel_on  (ch2_on),
      .volume      (cur_volume)
   );

   snd_square_gen u_square_gen (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .gen         (ch2_regs.gen),
      .channel_on  (ch2_on),
      .volume      (cur_volume),
      .sample      (ch2_sample)
   );

endmodule

/* testbench/tb_snd_channel2.sv */
`timescale 1ns/1ps

module tb_snd_channel2 import snd_reg_pkg::*; ();

   localparam int STEP     = 16;
   localparam int LEN_TICK = 2 * STEP;
   localparam int ENV_TICK = 8 * STEP;
   // Readback, length, envelope and duty phases in clocks
   localparam int TOTAL_CYCLES = 400 + 2 * (64 * LEN_TICK + 100) + 22 * ENV_TICK
                                 + 4 * (8 * 16 * 32 + 100);
   localparam int WATCHDOG_NS  = 2 * 8 * TOTAL_CYCLES;

   logic        I_CLK_33MHZ = 1'b0;
   logic        I_RESET     = 1'b1;
   ioreg_addr_t ioreg_addr  = '0;
   ioreg_data_t ioreg_wdata = '0;
   logic        ioreg_we    = 1'b0;
   logic        ioreg_re    = 1'b0;
   ioreg_data_t ioreg_rdata;
   logic        ch2_on;
   volume_t     ch2_sample;

   int          errors = 0;
   integer      seed   = 32'h20c2;
   int          cyc    = 0;
   int          trig_cyc;
   ioreg_data_t sh21, sh22, sh23, sh24;  // Bus-side copy of NR21..NR24
   volume_t     cap_v;
   logic        cap_inc;
   int          cap_p;
   int          cap_len;
   int          elapsed;
   int          n_lo;
   int          n_hi;
   volume_t     lvl_a;
   volume_t     lvl_b;
   ioreg_data_t rd_expect;
   logic        trig_wr;
   logic        dac_off_wr;
   logic        duty_start = 1'b0;
   int          win_len    = 0;
   int          win_left   = 0;
   int          hi_cnt     = 0;
   int          exp_hi     = 0;
   int          eighths [4] = '{1, 2, 4, 6};

   always #4 I_CLK_33MHZ = ~I_CLK_33MHZ;

   snd_channel2 #(.frame_step_cycles(STEP)) dut0 (.*);

   assign trig_wr    = ioreg_we && ioreg_addr == NR24_ADDR && ioreg_wdata[7];
   assign dac_off_wr = ioreg_we && ioreg_addr == NR22_ADDR && ioreg_wdata[7:3] == '0;

   always @(posedge I_CLK_33MHZ) begin
      cyc <= cyc + 1;
      if (I_RESET) begin
         {sh21, sh22, sh23, sh24} <= '0;
         {cap_v, cap_inc, cap_p, cap_len, trig_cyc} <= '0;
      end else begin
         if (ioreg_we) begin
            case (ioreg_addr)
               NR21_ADDR: sh21 <= ioreg_wdata;
               NR22_ADDR: sh22 <= ioreg_wdata;
               NR23_ADDR: sh23 <= ioreg_wdata;
               NR24_ADDR: sh24 <= ioreg_wdata;
               default: ;
            endcase
         end
         if (trig_wr) begin
            trig_cyc <= cyc;
            cap_v    <= sh22[7:4];
            cap_inc  <= sh22[3];
            cap_p    <= int'(sh22[2:0]);
            cap_len  <= int'(sh21[5:0]);
         end
      end
   end

   // Nonzero sample cycles over one measurement window
   always @(posedge I_CLK_33MHZ) begin
      if (duty_start) begin
         win_left <= win_len;
         hi_cnt   <= 0;
      end else if (win_left != 0) begin
         win_left <= win_left - 1;
         hi_cnt   <= hi_cnt + int'(ch2_sample != '0);
      end
   end

   function automatic volume_t level_after(input volume_t v, input logic inc, input int n);
      if (inc)
         return (int'(v) + n > 15) ? 4'd15 : volume_t'(int'(v) + n);
      return (n > int'(v)) ? 4'd0 : volume_t'(int'(v) - n);
   endfunction

   always_comb begin
      case (ioreg_addr)
         NR21_ADDR: rd_expect = sh21 | 8'h3F;  // Duty bits only
         NR22_ADDR: rd_expect = sh22;
         NR23_ADDR: rd_expect = sh23 | 8'hFF;  // Write-only
         NR24_ADDR: rd_expect = sh24 | 8'hBF;  // Length enable only
         default:   rd_expect = 8'hFF;
      endcase
      elapsed = cyc - trig_cyc;
      // Envelope steps already seen for the earliest and latest tick phase
      n_lo  = (cap_p == 0 || elapsed < 4) ? 0 : (elapsed - 4) / (cap_p * ENV_TICK);
      n_hi  = (cap_p == 0) ? 0 : (elapsed + ENV_TICK) / (cap_p * ENV_TICK);
      lvl_a = level_after(cap_v, cap_inc, n_lo);
      lvl_b = level_after(cap_v, cap_inc, n_hi);
   end

   a_reset_state: assert property (@(posedge I_CLK_33MHZ)
      $fell(I_RESET) |-> !ch2_on && ch2_sample == '0 && ioreg_rdata == '0)
      else report_error("outputs not zero after reset");
   a_readback: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      ioreg_re |=> ioreg_rdata == $past(rd_expect))
      else report_error("readback mismatch");
   a_rdata_held: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      !ioreg_re |=> $stable(ioreg_rdata))
      else report_error("ioreg_rdata changed without a read");
   a_trigger_on: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      (trig_wr && |sh22[7:3] && !ch2_on) |-> ##1 !ch2_on ##1 ch2_on)
      else report_error("ch2_on not raised two cycles after trigger");
   a_trigger_gated: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      (trig_wr && !(|sh22[7:3])) |-> ##2 !ch2_on)
      else report_error("ch2_on raised with the DAC off");
   a_dac_off: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      dac_off_wr |-> ##2 !ch2_on)
      else report_error("ch2_on still high after DAC off write");
   a_fall_cause: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      $fell(ch2_on) |-> $past(dac_off_wr, 2) || (sh24[6] &&
         elapsed >= (63 - cap_len) * LEN_TICK && elapsed <= (64 - cap_len) * LEN_TICK + 4))
      else report_error("ch2_on fell outside the length window");
   a_env_band: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      ch2_sample != '0 |-> (ch2_sample >= lvl_a && ch2_sample <= lvl_b) ||
                           (ch2_sample >= lvl_b && ch2_sample <= lvl_a))
      else report_error("sample level off the envelope");
   a_silent_off: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      !ch2_on |=> ch2_sample == '0)
      else report_error("sample nonzero while channel off");
   a_duty_count: assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      win_left == 1 |=> hi_cnt == exp_hi)
      else report_error("wrong high time over one waveform period");

   task automatic report_error(input string msg);
      errors++;
      $display("Fail %0t: %s", $time, msg);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge I_CLK_33MHZ);
      #1;
   endtask

   task automatic write_reg(input ioreg_addr_t addr, input ioreg_data_t data);
      wait_cycles(1);
      ioreg_addr  = addr;
      ioreg_wdata = data;
      ioreg_we    = 1'b1;
      wait_cycles(1);
      ioreg_we = 1'b0;
   endtask

   task automatic read_reg(input ioreg_addr_t addr);
      wait_cycles(1);
      ioreg_addr = addr;
      ioreg_re   = 1'b1;
      wait_cycles(1);
      ioreg_re = 1'b0;
   endtask

   task automatic start_channel(input duty_t duty, input length_t len, input ioreg_data_t nr22,
                                input freq_t freq, input logic len_en);
      write_reg(NR22_ADDR, nr22);
      write_reg(NR24_ADDR, {5'b0, freq[10:8]});  // Length counter held until trigger
      write_reg(NR23_ADDR, freq[7:0]);
      write_reg(NR21_ADDR, {duty, len});
      write_reg(NR24_ADDR, {1'b1, len_en, 3'b0, freq[10:8]});
   endtask

   task automatic stop_channel();
      write_reg(NR22_ADDR, 8'h00);
      wait_cycles(4);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the test sequence did not complete");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      freq_t freq;
      int    len;
      wait_cycles(10);
      I_RESET = 1'b0;
      repeat (4) begin
         write_reg(NR21_ADDR, ioreg_data_t'($random(seed)));
         write_reg(NR22_ADDR, ioreg_data_t'($random(seed)));
         write_reg(NR23_ADDR, ioreg_data_t'($random(seed)));
         write_reg(NR24_ADDR, ioreg_data_t'($random(seed)) & 8'h7F);  // No trigger
         read_reg(NR21_ADDR);
         read_reg(NR22_ADDR);
         read_reg(NR23_ADDR);
         read_reg(NR24_ADDR);
         read_reg(ioreg_addr_t'($random(seed)));
      end
      start_channel(2'd2, 6'd0, 8'h00, 11'h7FF, 1'b0);
      wait_cycles(4);
      start_channel(2'd2, 6'd0, 8'h08, 11'h7FF, 1'b0);  // Silent but DAC on
      wait_cycles(8);
      stop_channel();
      len = 48 + ($random(seed) & 15);
      start_channel(2'd2, length_t'(len), 8'hF0, 11'h7FF, 1'b1);
      do wait_cycles(1); while (ch2_on);
      stop_channel();
      start_channel(2'd2, length_t'(len), 8'hF0, 11'h7FF, 1'b0);
      wait_cycles((64 - len) * LEN_TICK + 64);
      stop_channel();
      start_channel(2'd3, 6'd0, 8'h31, 11'h7FF, 1'b0);  // Down to zero
      wait_cycles(6 * ENV_TICK);
      stop_channel();
      start_channel(2'd3, 6'd0, 8'hCA, 11'h7FF, 1'b0);  // Up to 15
      wait_cycles(12 * ENV_TICK);
      stop_channel();
      start_channel(2'd3, 6'd0, 8'h90, 11'h7FF, 1'b0);
      wait_cycles(4 * ENV_TICK);
      stop_channel();
      for (int d = 0; d < 4; d++) begin
         freq = 11'h7FF - freq_t'($random(seed) & 15);
         start_channel(duty_t'(d), 6'd0, 8'hA0, freq, 1'b0);
         wait_cycles(4);
         win_len    = 8 * (2048 - int'(freq)) * 32;
         exp_hi     = eighths[d] * (2048 - int'(freq)) * 32;
         duty_start = 1'b1;
         wait_cycles(1);
         duty_start = 1'b0;
         do wait_cycles(1); while (win_left != 0);
         stop_channel();
      end
      wait_cycles(10);
      $display("Checks failed: %0d", errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* list.f */
src/snd_reg_pkg.sv
src/snd_timing_pkg.sv
src/snd_ch2_reg_if.sv
src/snd_ioreg_file.sv
src/snd_frame_sequencer.sv
src/snd_length_envelope.sv
src/snd_square_gen.sv
src/snd_channel2.sv
testbench/tb_snd_channel2.sv
